// File: ctrl_mon_top.f
+incdir+.
ctrl_mon_pkg.sv
pc_set_checker.sv
fencei_hs_checker.sv
obi_err_tracker.sv
violation_log.sv
ctrl_mon_top.sv
tb_clk_gen.sv
tb_ctrl_mon.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ctrl_mon
FLIST     ?= ctrl_mon_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_ctrl_mon.sv
// Directed tests run in order and each one expects the log to be clear when it starts
`include "ctrl_mon_defines.svh"

module tb_ctrl_mon;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int AW         = `CTRL_MON_WB_AW;
  localparam int DW         = `CTRL_MON_WB_DW;
  localparam int WAIT_LIMIT = 40;

  logic                    clk;
  logic                    rst_n;
  logic                    pc_set;
  ctrl_mon_pkg::pc_mux_e   pc_mux;
  logic                    csr_wr_in_wb;
  logic                    fencei_in_wb;
  logic                    fencei_ready;
  logic                    fencei_flush_req;
  logic                    fencei_flush_ack;
  logic                    obi_req;
  logic                    obi_gnt;
  logic                    obi_we;
  logic                    obi_rvalid;
  logic                    obi_err;
  logic                    wb_valid;
  logic                    debug_mode;
  logic                    step_noirq;
  logic                    nmi_is_store;
  logic                    nmi_pending;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [AW-1:0]           wb_adr;
  logic [DW-1:0]           wb_dat_w;
  logic [DW-1:0]           wb_dat_r;
  logic                    wb_ack;
  logic                    irq;

  tb_clk_gen clk_gen0 (.clk_o(clk), .rst_n_o(rst_n));

  ctrl_mon_top dut0 (
    .clk(clk), .rst_n(rst_n),
    .pc_set_i(pc_set), .pc_mux_i(pc_mux), .csr_wr_in_wb_i(csr_wr_in_wb),
    .fencei_in_wb_i(fencei_in_wb), .fencei_ready_i(fencei_ready),
    .fencei_flush_req_i(fencei_flush_req), .fencei_flush_ack_i(fencei_flush_ack),
    .obi_req_i(obi_req), .obi_gnt_i(obi_gnt), .obi_we_i(obi_we),
    .obi_rvalid_i(obi_rvalid), .obi_err_i(obi_err),
    .wb_valid_i(wb_valid), .debug_mode_i(debug_mode), .step_noirq_i(step_noirq),
    .nmi_is_store_i(nmi_is_store), .nmi_pending_i(nmi_pending),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack), .irq_o(irq)
  );

  //////////////////////////////////////////////////
  // Failure, masks and bus access
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // Status bit n-1 belongs to violation code n
  function automatic ctrl_mon_pkg::viol_vec_t code_mask(input ctrl_mon_pkg::viol_e code);
    ctrl_mon_pkg::viol_vec_t vec;
    vec = '0;
    vec[int'(code) - 1] = 1'b1;
    return vec;
  endfunction

  // Outputs are sampled on the falling edge, half a cycle away from any update
  task automatic wait_ack(output logic [DW-1:0] rdat);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!wb_ack && (waited < WAIT_LIMIT)) begin
      @(negedge clk);
      waited++;
    end
    if (!wb_ack) begin
      abort_run("The Wishbone slave never acknowledged the access");
    end
    rdat = wb_dat_r;
    // Master drops stb right after the ack cycle
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [AW-1:0] adr, input logic [DW-1:0] data);
    logic [DW-1:0] unused;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= data;
    wait_ack(unused);
  endtask

  task automatic wb_read(input logic [AW-1:0] adr, output logic [DW-1:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    wait_ack(data);
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_status(input ctrl_mon_pkg::viol_vec_t expected);
    logic [DW-1:0] data;
    wb_read(`CTRL_MON_REG_STATUS, data);
    if (data !== DW'(expected)) begin
      abort_run($sformatf("ERROR at %0t ns: STATUS reads %h, expected %h",
                          $time, data, expected));
    end
  endtask

  task automatic check_code(input ctrl_mon_pkg::viol_e expected);
    logic [DW-1:0] data;
    wb_read(`CTRL_MON_REG_FIRST, data);
    if (data !== DW'(expected)) begin
      abort_run($sformatf("ERROR at %0t ns: FIRST reads %0d, expected %0d (%s)",
                          $time, data, expected, expected.name()));
    end
  endtask

  task automatic check_count(input logic [7:0] expected);
    logic [DW-1:0] data;
    wb_read(`CTRL_MON_REG_COUNT, data);
    if (data !== DW'(expected)) begin
      abort_run($sformatf("ERROR at %0t ns: COUNT reads %0d, expected %0d",
                          $time, data, expected));
    end
  endtask

  task automatic check_irq(input logic expected);
    @(negedge clk);
    if (irq !== expected) begin
      abort_run($sformatf("ERROR at %0t ns: irq_o is %b, expected %b", $time, irq, expected));
    end
  endtask

  //////////////////////////////////////////////////
  // Waits and stimulus
  //////////////////////////////////////////////////

  // Polls STATUS until every bit of the mask has landed
  task automatic wait_status(input ctrl_mon_pkg::viol_vec_t mask);
    logic [DW-1:0] data;
    int            tries;
    tries = 0;
    wb_read(`CTRL_MON_REG_STATUS, data);
    while (((data & DW'(mask)) != DW'(mask)) && (tries < WAIT_LIMIT)) begin
      wb_read(`CTRL_MON_REG_STATUS, data);
      tries++;
    end
    if ((data & DW'(mask)) != DW'(mask)) begin
      abort_run("The expected violation flags were never set");
    end
  endtask

  // A sampled rule input reaches the sticky flags two edges later
  task automatic settle();
    repeat (3) @(posedge clk);
  endtask

  task automatic clear_log();
    wb_write(`CTRL_MON_REG_STATUS, '1);
    wb_write(`CTRL_MON_REG_COUNT, '0);
  endtask

  task automatic redirect(input ctrl_mon_pkg::pc_mux_e kind, input logic csr_wr, input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      pc_set       <= 1'b1;
      pc_mux       <= kind;
      csr_wr_in_wb <= csr_wr;
    end
    @(posedge clk);
    pc_set       <= 1'b0;
    pc_mux       <= ctrl_mon_pkg::PC_BOOT;
    csr_wr_in_wb <= 1'b0;
  endtask

  task automatic fencei_step(input logic in_wb, input logic req, input logic ack);
    @(posedge clk);
    fencei_in_wb     <= in_wb;
    fencei_flush_req <= req;
    fencei_flush_ack <= ack;
  endtask

  // Grant follows request at once, as on a zero-wait data bus
  task automatic bus_step(input logic req, input logic we, input logic rvalid, input logic err);
    @(posedge clk);
    obi_req    <= req;
    obi_gnt    <= req;
    obi_we     <= we;
    obi_rvalid <= rvalid;
    obi_err    <= err;
  endtask

  // Write then read in flight, error on the write, then retirements and the NMI trap
  task automatic bus_error_nmi(input logic nmi_store, input int retirements);
    bus_step(1'b1, 1'b1, 1'b0, 1'b0);
    bus_step(1'b1, 1'b0, 1'b0, 1'b0);
    bus_step(1'b0, 1'b0, 1'b1, 1'b1);
    nmi_pending  <= 1'b1;
    nmi_is_store <= nmi_store;
    bus_step(1'b0, 1'b0, 1'b1, 1'b0);
    bus_step(1'b0, 1'b0, 1'b0, 1'b0);
    repeat (retirements) begin
      @(posedge clk);
      wb_valid <= 1'b1;
    end
    @(posedge clk);
    wb_valid <= 1'b0;
    redirect(ctrl_mon_pkg::PC_TRAP_NMI, 1'b0, 1);
    nmi_pending  <= 1'b0;
    nmi_is_store <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_quiet();
    check_status('0);
    check_code(ctrl_mon_pkg::V_NONE);
    check_count(8'd0);
    check_irq(1'b0);
    redirect(ctrl_mon_pkg::PC_BRANCH, 1'b0, 1);
    redirect(ctrl_mon_pkg::PC_JUMP, 1'b0, 1);
    // Legal flush: request, acknowledge, then request drops at once
    fencei_step(1'b1, 1'b1, 1'b0);
    fencei_step(1'b1, 1'b1, 1'b1);
    fencei_step(1'b0, 1'b0, 1'b0);
    settle();
    check_status('0);
    check_code(ctrl_mon_pkg::V_NONE);
    check_count(8'd0);
  endtask

  task automatic test_redirects();
    redirect(ctrl_mon_pkg::PC_BRANCH, 1'b0, 2);
    wait_status(code_mask(ctrl_mon_pkg::V_B2B_BRANCH));
    check_status(code_mask(ctrl_mon_pkg::V_B2B_BRANCH));
    check_code(ctrl_mon_pkg::V_B2B_BRANCH);
    clear_log();
    redirect(ctrl_mon_pkg::PC_MRET, 1'b1, 1);
    wait_status(code_mask(ctrl_mon_pkg::V_XRET_CSR));
    check_status(code_mask(ctrl_mon_pkg::V_XRET_CSR));
    check_code(ctrl_mon_pkg::V_XRET_CSR);
  endtask

  task automatic test_fencei();
    ctrl_mon_pkg::viol_vec_t both;
    both = code_mask(ctrl_mon_pkg::V_FENCEI_NO_INSN) | code_mask(ctrl_mon_pkg::V_FENCEI_STUCK);
    // Acknowledged request with no fence.i in writeback
    fencei_step(1'b0, 1'b1, 1'b1);
    fencei_step(1'b0, 1'b0, 1'b0);
    // Request held one cycle past request and acknowledge
    fencei_step(1'b1, 1'b1, 1'b1);
    fencei_step(1'b1, 1'b1, 1'b1);
    fencei_step(1'b0, 1'b0, 1'b0);
    wait_status(both);
    check_status(both);
    check_code(ctrl_mon_pkg::V_FENCEI_NO_INSN);
    check_count(8'd2);
  endtask

  task automatic test_nmi_ok();
    bus_error_nmi(1'b1, 1);
    settle();
    check_status('0);
    check_code(ctrl_mon_pkg::V_NONE);
    check_count(8'd0);
  endtask

  task automatic test_nmi_late();
    ctrl_mon_pkg::viol_vec_t both;
    both = code_mask(ctrl_mon_pkg::V_NMI_TYPE) | code_mask(ctrl_mon_pkg::V_NMI_LATE);
    bus_error_nmi(1'b0, 3);
    wait_status(both);
    check_status(both);
    check_code(ctrl_mon_pkg::V_NMI_TYPE);
    check_count(8'd2);
    // Clearing one flag leaves the other one sticky
    wb_write(`CTRL_MON_REG_STATUS, DW'(code_mask(ctrl_mon_pkg::V_NMI_TYPE)));
    check_status(code_mask(ctrl_mon_pkg::V_NMI_LATE));
    check_irq(1'b1);
  endtask

  task automatic wait_reset();
    int waited;
    waited = 0;
    while (!rst_n && (waited < WAIT_LIMIT)) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      abort_run("Reset was never released");
    end
  endtask

  initial begin
    pc_set           = 1'b0;
    pc_mux           = ctrl_mon_pkg::PC_BOOT;
    csr_wr_in_wb     = 1'b0;
    fencei_in_wb     = 1'b0;
    fencei_ready     = 1'b1;
    fencei_flush_req = 1'b0;
    fencei_flush_ack = 1'b0;
    obi_req          = 1'b0;
    obi_gnt          = 1'b0;
    obi_we           = 1'b0;
    obi_rvalid       = 1'b0;
    obi_err          = 1'b0;
    wb_valid         = 1'b0;
    debug_mode       = 1'b0;
    step_noirq       = 1'b0;
    nmi_is_store     = 1'b0;
    nmi_pending      = 1'b0;
    wb_cyc           = 1'b0;
    wb_stb           = 1'b0;
    wb_we            = 1'b0;
    wb_adr           = '0;
    wb_dat_w         = '0;
    wait_reset();
    test_reset_quiet();
    clear_log();
    test_redirects();
    clear_log();
    test_fencei();
    clear_log();
    test_nmi_ok();
    clear_log();
    test_nmi_late();
    $display("test passed");
    $finish;
  end

endmodule

// File: tb_clk_gen.sv
// Free-running clock with a 100 ns period; reset is held low for the first ten rising edges only
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD) clk_o = ~clk_o;
    end
  end

  // Release on a rising edge, like every other driven input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: ctrl_mon_top.sv
// Passive monitor with no path back into the core; the bus master must drop stb after ack
`include "ctrl_mon_defines.svh"

module ctrl_mon_top (
  input  logic                       clk,
  input  logic                       rst_n,
  // Controller redirect
  input  logic                       pc_set_i,
  input  ctrl_mon_pkg::pc_mux_e      pc_mux_i,
  input  logic                       csr_wr_in_wb_i,
  // Fence.i handshake
  input  logic                       fencei_in_wb_i,
  input  logic                       fencei_ready_i,
  input  logic                       fencei_flush_req_i,
  input  logic                       fencei_flush_ack_i,
  // OBI data bus
  input  logic                       obi_req_i,
  input  logic                       obi_gnt_i,
  input  logic                       obi_we_i,
  input  logic                       obi_rvalid_i,
  input  logic                       obi_err_i,
  // Retirement and NMI state
  input  logic                       wb_valid_i,
  input  logic                       debug_mode_i,
  input  logic                       step_noirq_i,
  input  logic                       nmi_is_store_i,
  input  logic                       nmi_pending_i,
  // Register port
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`CTRL_MON_WB_AW-1:0] wb_adr_i,
  input  logic [`CTRL_MON_WB_DW-1:0] wb_dat_i,
  output logic [`CTRL_MON_WB_DW-1:0] wb_dat_o,
  output logic                       wb_ack_o,
  output logic                       irq_o
);

  ctrl_mon_pkg::viol_vec_t pc_viol;
  ctrl_mon_pkg::viol_vec_t fencei_viol;
  ctrl_mon_pkg::viol_vec_t obi_viol;
  ctrl_mon_pkg::viol_vec_t all_viol;

  // Checkers own disjoint bits, so an OR merges them without loss
  assign all_viol = pc_viol | fencei_viol | obi_viol;

  pc_set_checker u_pc_set (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .pc_mux_i       (pc_mux_i),
    .csr_wr_in_wb_i (csr_wr_in_wb_i),
    .viol_o         (pc_viol)
  );

  fencei_hs_checker u_fencei (
    .clk                (clk),
    .rst_n              (rst_n),
    .fencei_in_wb_i     (fencei_in_wb_i),
    .fencei_ready_i     (fencei_ready_i),
    .fencei_flush_req_i (fencei_flush_req_i),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .viol_o             (fencei_viol)
  );

  obi_err_tracker u_obi_err (
    .clk            (clk),
    .rst_n          (rst_n),
    .obi_req_i      (obi_req_i),
    .obi_gnt_i      (obi_gnt_i),
    .obi_we_i       (obi_we_i),
    .obi_rvalid_i   (obi_rvalid_i),
    .obi_err_i      (obi_err_i),
    .pc_set_i       (pc_set_i),
    .pc_mux_i       (pc_mux_i),
    .wb_valid_i     (wb_valid_i),
    .debug_mode_i   (debug_mode_i),
    .step_noirq_i   (step_noirq_i),
    .nmi_is_store_i (nmi_is_store_i),
    .nmi_pending_i  (nmi_pending_i),
    .viol_o         (obi_viol)
  );

  violation_log u_log (
    .clk      (clk),
    .rst_n    (rst_n),
    .viol_i   (all_viol),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .irq_o    (irq_o)
  );

endmodule

// File: violation_log.sv
// Single-cycle Wishbone classic slave with no wait states; unmapped offsets read 0 and ignore writes
`include "ctrl_mon_defines.svh"

module violation_log (
  input  logic                         clk,
  input  logic                         rst_n,
  input  ctrl_mon_pkg::viol_vec_t      viol_i,
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [`CTRL_MON_WB_AW-1:0]   wb_adr_i,
  input  logic [`CTRL_MON_WB_DW-1:0]   wb_dat_i,
  output logic [`CTRL_MON_WB_DW-1:0]   wb_dat_o,
  output logic                         wb_ack_o,
  output logic                         irq_o
);

  logic                    req;
  logic                    wr_status;
  logic                    wr_count;
  ctrl_mon_pkg::viol_vec_t clr_mask;
  ctrl_mon_pkg::viol_vec_t kept;
  ctrl_mon_pkg::viol_vec_t flags_d;
  ctrl_mon_pkg::viol_vec_t flags_q;
  ctrl_mon_pkg::viol_e     first_q;
  logic [7:0]              count_q;
  logic [8:0]              count_sum;

  // Lowest code wins when several violations arrive together
  function automatic ctrl_mon_pkg::viol_e lowest_code(input ctrl_mon_pkg::viol_vec_t vec);
    ctrl_mon_pkg::viol_e code;
    code = ctrl_mon_pkg::V_NONE;
    for (int i = $bits(vec) - 1; i >= 0; i--) begin
      if (vec[i]) begin
        code = ctrl_mon_pkg::viol_e'(4'(i + 1));
      end
    end
    return code;
  endfunction

  //////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////

  // A request is new only while no ack is out, so a held stb is served once
  assign req       = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_status = req && wb_we_i && (wb_adr_i == `CTRL_MON_REG_STATUS);
  assign wr_count  = req && wb_we_i && (wb_adr_i == `CTRL_MON_REG_COUNT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;
    end
  end

  // Address is held by the master until ack, so the mux needs no register
  always_comb begin
    wb_dat_o = '0;
    case (wb_adr_i)
      `CTRL_MON_REG_STATUS: wb_dat_o[$bits(flags_q)-1:0] = flags_q;
      `CTRL_MON_REG_FIRST:  wb_dat_o[$bits(first_q)-1:0] = first_q;
      `CTRL_MON_REG_COUNT:  wb_dat_o[$bits(count_q)-1:0] = count_q;
      default:              wb_dat_o = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Sticky flags, first code and count
  //////////////////////////////////////////////////

  // New pulses are ORed in after the clear so they are never lost
  assign clr_mask  = wr_status ? wb_dat_i[$bits(clr_mask)-1:0] : '0;
  assign kept      = flags_q & ~clr_mask;
  assign flags_d   = kept | viol_i;
  assign count_sum = (wr_count ? 9'd0 : {1'b0, count_q}) + 9'($countones(viol_i));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
      first_q <= ctrl_mon_pkg::V_NONE;
      count_q <= 8'd0;
    end else begin
      flags_q <= flags_d;
      // First code restarts only from an all-clear state
      if (flags_d == '0) begin
        first_q <= ctrl_mon_pkg::V_NONE;
      end else if (kept == '0) begin
        first_q <= lowest_code(viol_i);
      end
      count_q <= count_sum[8] ? 8'hff : count_sum[7:0];
    end
  end

  assign irq_o = |flags_q;

  // The master ends each access by dropping stb in the cycle after ack
  a_stb_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack_o |=> !wb_stb_i);

endmodule

// File: obi_err_tracker.sv
// Follows at most two outstanding OBI data transactions; only the first bus error until the NMI trap counts
`include "ctrl_mon_defines.svh"

module obi_err_tracker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  obi_req_i,
  input  logic                  obi_gnt_i,
  input  logic                  obi_we_i,
  input  logic                  obi_rvalid_i,
  input  logic                  obi_err_i,
  input  logic                  pc_set_i,
  input  ctrl_mon_pkg::pc_mux_e pc_mux_i,
  input  logic                  wb_valid_i,
  input  logic                  debug_mode_i,
  input  logic                  step_noirq_i,
  input  logic                  nmi_is_store_i,
  input  logic                  nmi_pending_i,
  output ctrl_mon_pkg::viol_vec_t viol_o
);

  logic       granted;
  logic       err_first;
  logic       nmi_taken;
  logic       retire;
  logic [1:0] out_cnt_q;
  logic [1:0] out_we_q;
  logic       oldest_we;
  logic       err_is_write_q;
  logic       err_latched_q;
  logic       err_new_q;
  logic [1:0] retire_cnt_q;
  ctrl_mon_pkg::viol_vec_t viol_d;

  assign granted   = obi_req_i && obi_gnt_i;
  assign err_first = obi_rvalid_i && obi_err_i && !err_latched_q;
  assign nmi_taken = pc_set_i && (pc_mux_i == ctrl_mon_pkg::PC_TRAP_NMI);
  // Retirements in debug mode or in single step without interrupts
  // cannot be preempted by the NMI, so they are not counted
  assign retire    = wb_valid_i && !debug_mode_i && !step_noirq_i;

  // With two in flight the older one sits in the upper entry
  assign oldest_we = (out_cnt_q == 2'd2) ? out_we_q[1] : out_we_q[0];

  //////////////////////////////////////////////////
  // Outstanding transaction bookkeeping
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q <= 2'd0;
    end else begin
      case ({granted, obi_rvalid_i})
        2'b10:   out_cnt_q <= out_cnt_q + 2'd1;
        2'b01:   out_cnt_q <= out_cnt_q - 2'd1;
        default: out_cnt_q <= out_cnt_q;
      endcase
    end
  end

  // Shifting on every grant is safe because the count picks the entry
  always_ff @(posedge clk) begin
    if (granted) begin
      out_we_q <= {out_we_q[0], obi_we_i};
    end
    if (err_first) begin
      err_is_write_q <= oldest_we;
    end
  end

  //////////////////////////////////////////////////
  // Error latch and retirement count
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_latched_q <= 1'b0;
      err_new_q     <= 1'b0;
      retire_cnt_q  <= 2'd0;
    end else begin
      err_new_q <= err_first;
      if (err_first) begin
        err_latched_q <= 1'b1;
      end else if (nmi_taken) begin
        err_latched_q <= 1'b0;
      end
      // Saturates at one past the allowed number of retirements
      if (!err_latched_q) begin
        retire_cnt_q <= 2'd0;
      end else if (retire && (retire_cnt_q <= 2'(`CTRL_MON_MAX_RETIRE))) begin
        retire_cnt_q <= retire_cnt_q + 2'd1;
      end
    end
  end

  always_comb begin
    viol_d = '0;
    // The controller must mirror the error direction one cycle later
    viol_d[ctrl_mon_pkg::V_NMI_TYPE - 1] =
      err_new_q && !(nmi_pending_i && (nmi_is_store_i == err_is_write_q));
    // Fires on the retirement that takes the count past the limit
    viol_d[ctrl_mon_pkg::V_NMI_LATE - 1] =
      err_latched_q && retire && (retire_cnt_q == 2'(`CTRL_MON_MAX_RETIRE));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      viol_o <= '0;
    end else begin
      viol_o <= viol_d;
    end
  end

  // The core never has more transactions in flight than the history holds
  a_outstanding_limit: assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_q <= 2'(`CTRL_MON_MAX_OUTSTANDING));

endmodule

// File: fencei_hs_checker.sv
// Watches the fence.i flush handshake only; wb_valid after completion is not checked here
module fencei_hs_checker (
  input  logic clk,
  input  logic rst_n,
  input  logic fencei_in_wb_i,
  input  logic fencei_ready_i,
  input  logic fencei_flush_req_i,
  input  logic fencei_flush_ack_i,
  output ctrl_mon_pkg::viol_vec_t viol_o
);

  logic req_q;
  logic req_ack_q;
  ctrl_mon_pkg::viol_vec_t viol_d;

  //////////////////////////////////////////////////
  // Handshake rules
  //////////////////////////////////////////////////

  always_comb begin
    viol_d = '0;

    // The flush request belongs to a fence.i in writeback
    viol_d[ctrl_mon_pkg::V_FENCEI_NO_INSN - 1] =
      fencei_flush_req_i && !fencei_in_wb_i;

    // The write buffer must be empty for the whole handshake
    viol_d[ctrl_mon_pkg::V_FENCEI_NOT_READY - 1] =
      fencei_flush_req_i && !fencei_ready_i;

    // Request may only drop once the cache has acknowledged it
    // Since req_q was high, req_ack_q equals the previous acknowledge
    viol_d[ctrl_mon_pkg::V_FENCEI_EARLY_CLEAR - 1] =
      req_q && !fencei_flush_req_i && !req_ack_q;

    // After request and acknowledge the request must go low at once
    viol_d[ctrl_mon_pkg::V_FENCEI_STUCK - 1] =
      fencei_flush_req_i && req_ack_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q     <= 1'b0;
      req_ack_q <= 1'b0;
      viol_o    <= '0;
    end else begin
      req_q     <= fencei_flush_req_i;
      req_ack_q <= fencei_flush_req_i && fencei_flush_ack_i;
      viol_o    <= viol_d;
    end
  end

endmodule

// File: pc_set_checker.sv
// Jump class includes MRET but not DRET; checks assume pc_set_i is a one-cycle strobe per redirect
module pc_set_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pc_set_i,
  input  ctrl_mon_pkg::pc_mux_e pc_mux_i,
  input  logic                  csr_wr_in_wb_i,
  output ctrl_mon_pkg::viol_vec_t viol_o
);

  logic branch_set;
  logic jump_set;
  logic xret_set;
  logic branch_q;
  logic jump_q;
  ctrl_mon_pkg::viol_vec_t viol_d;

  // Classify the redirect in this cycle
  assign branch_set = pc_set_i && (pc_mux_i == ctrl_mon_pkg::PC_BRANCH);
  assign jump_set   = pc_set_i && ((pc_mux_i == ctrl_mon_pkg::PC_JUMP) ||
                                   (pc_mux_i == ctrl_mon_pkg::PC_MRET));
  assign xret_set   = pc_set_i && ((pc_mux_i == ctrl_mon_pkg::PC_MRET) ||
                                   (pc_mux_i == ctrl_mon_pkg::PC_DRET));

  // The core kills the fetch stages after a redirect, so the same class
  // of redirect can never follow in the very next cycle
  always_comb begin
    viol_d = '0;
    viol_d[ctrl_mon_pkg::V_B2B_BRANCH - 1] = branch_set && branch_q;
    viol_d[ctrl_mon_pkg::V_B2B_JUMP - 1]   = jump_set && jump_q;
    // A return must not race a CSR write that may change its target
    viol_d[ctrl_mon_pkg::V_XRET_CSR - 1]   = xret_set && csr_wr_in_wb_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      branch_q <= 1'b0;
      jump_q   <= 1'b0;
      viol_o   <= '0;
    end else begin
      branch_q <= branch_set;
      jump_q   <= jump_set;
      viol_o   <= viol_d;
    end
  end

  // History registers start empty, so no stale redirect can fire a pulse
  a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> (viol_o == '0));

endmodule

// File: ctrl_mon_pkg.sv
// Violation code n always maps to status bit n-1, so new codes must be appended at the end
package ctrl_mon_pkg;

  // Program counter redirect kinds as the controller encodes them
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_DRET     = 3'd4,
    PC_TRAP_EXC = 3'd5,
    PC_TRAP_IRQ = 3'd6,
    PC_TRAP_NMI = 3'd7
  } pc_mux_e;

  // Violation codes reported through the FIRST register
  // Code 0 means that nothing has been seen yet
  typedef enum logic [3:0] {
    V_NONE               = 4'd0,
    V_B2B_BRANCH         = 4'd1,
    V_B2B_JUMP           = 4'd2,
    V_XRET_CSR           = 4'd3,
    V_FENCEI_NO_INSN     = 4'd4,
    V_FENCEI_EARLY_CLEAR = 4'd5,
    V_FENCEI_STUCK       = 4'd6,
    V_FENCEI_NOT_READY   = 4'd7,
    V_NMI_TYPE           = 4'd8,
    V_NMI_LATE           = 4'd9
  } viol_e;

  // One bit per nonzero code
  typedef logic [8:0] viol_vec_t;

endpackage

// File: ctrl_mon_defines.svh
// Widths and offsets are fixed for a 4-bit byte-addressed Wishbone port; the tracker follows two transactions
`ifndef CTRL_MON_DEFINES_SVH
`define CTRL_MON_DEFINES_SVH

//////////////////////////////////////////////////
// Wishbone slave port
//////////////////////////////////////////////////

// Address and data widths of the register port
`define CTRL_MON_WB_AW 4
`define CTRL_MON_WB_DW 32

// Sticky flags, read to see them and write ones to clear them
`define CTRL_MON_REG_STATUS 4'h0
// Code of the first violation since the flags were last all clear
`define CTRL_MON_REG_FIRST 4'h4
// Saturating violation count, any write clears it
`define CTRL_MON_REG_COUNT 4'h8

//////////////////////////////////////////////////
// Data bus error tracker limits
//////////////////////////////////////////////////

// Most data transactions the core keeps in flight
`define CTRL_MON_MAX_OUTSTANDING 2
// Retirements allowed between the bus error and the NMI trap
`define CTRL_MON_MAX_RETIRE 2

`endif
